/* bench/rec_store_tb.sv */
// Record store testbench
// Trace reader, command driver, response monitor, LFSR timing, timeout
`default_nettype none

module rec_store_tb;
  import rec_pkg::*;

  localparam logic [31:0] SEED = 32'hbae4_7cbe;

  logic clk;
  logic reset_N;
  logic cmd_valid;
  logic cmd_ready;
  cmd_t cmd;
  logic rsp_valid;
  logic rsp_ready;
  rsp_t rsp;

  // Parsed trace
  cmd_t  cmd_q[$];
  int    cmd_test[$];    // Owning test of each command
  rsp_t  exp_q[$];       // Responses in arrival order
  string test_name[$];
  logic  test_gaps[$];   // Random idle cycles between commands
  logic  test_bp[$];     // rsp_ready low in stretches
  int    exp_before[$];  // Responses expected ahead of each test
  int    test_err[$];

  int          exp_done;   // Responses checked so far
  int          rep_test;   // First test not yet reported
  int          errors;
  int          n_pass;
  int          n_fail;
  int          cycles;
  int          limit;      // Zero until the trace is loaded
  logic [31:0] drv_st;     // Driver LFSR state
  logic [31:0] mon_st;     // Monitor LFSR state

  rec_store_top i_rec_store_top (
    .clk       (clk),
    .reset_N   (reset_N),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Run limit from the trace length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: responses stopped arriving, %0d of %0d seen after %0d cycles",
               exp_done, exp_q.size(), cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Index one past the last expected response of test t
  function automatic int test_end(input int t);
    return (t + 1 < test_name.size()) ? exp_before[t + 1] : exp_q.size();
  endfunction

  task check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: %s = %h, expected %h (response %0d)", name, got, exp, exp_done);
      errors++;
      if (rep_test < test_name.size()) test_err[rep_test]++;
    end
  endtask

  task read_trace;
    int               fd;
    int               rc;
    int               g;
    int               b;
    string            kw;
    string            name;
    op_t              op;
    addr_t            addr;
    tag_t             tag;
    word_t            data;
    logic             err;
    cmd_t             c;
    rsp_t             r;
    logic [8*128-1:0] skip_line;
    begin
      fd = $fopen("bench/rec_store_trace.txt", "r");
      if (fd == 0) begin
        $display("cannot open the trace file bench/rec_store_trace.txt");
        errors++;
      end else begin
        while ($fscanf(fd, "%s", kw) == 1) begin
          if (kw == "#") begin
            rc = $fgets(skip_line, fd);  // Column notes
          end else if (kw == "test") begin
            rc = $fscanf(fd, "%s %d %d", name, g, b);
            if (rc != 3) begin
              $display("trace has a test line with missing fields");
              errors++;
            end
            test_name.push_back(name);
            test_gaps.push_back(g != 0);
            test_bp.push_back(b != 0);
            exp_before.push_back(exp_q.size());
            test_err.push_back(0);
          end else if (kw == "cmd") begin
            rc = $fscanf(fd, "%h %h %h %h", op, addr, tag, data);
            if (rc != 4) begin
              $display("trace has a cmd line with missing fields");
              errors++;
            end
            c.op   = op;
            c.addr = addr;
            c.tag  = tag;
            c.data = data;
            cmd_q.push_back(c);
            cmd_test.push_back(test_name.size() - 1);
          end else if (kw == "exp") begin
            rc = $fscanf(fd, "%h %h %h", tag, data, err);
            if (rc != 3) begin
              $display("trace has an exp line with missing fields");
              errors++;
            end
            r.tag  = tag;
            r.data = data;
            r.err  = err;
            exp_q.push_back(r);
          end else begin
            $display("trace has a line of unknown kind: %s", kw);
            errors++;
          end
        end
        $fclose(fd);
      end
    end
  endtask

  // One line per test once all its responses are in
  task report_finished;
    while (rep_test < test_name.size() && exp_done >= test_end(rep_test)) begin
      if (test_err[rep_test] == 0) begin
        $display("test %s: pass", test_name[rep_test]);
        n_pass++;
      end else begin
        $display("test %s: %0d mismatches", test_name[rep_test], test_err[rep_test]);
        n_fail++;
      end
      rep_test++;
    end
  endtask

  task drive_commands;
    int i;
    int t;
    begin
      for (i = 0; i < cmd_q.size(); i++) begin
        t = cmd_test[i];
        // New test waits for earlier tests to drain
        if (i == 0 || t != cmd_test[i - 1]) begin
          while (exp_done < exp_before[t]) begin
            @(posedge clk);
            #2;
          end
        end
        if (test_gaps[t]) begin
          drv_st = lfsr_step(drv_st);
          while (drv_st[0]) begin  // One idle cycle per 1 bit
            @(posedge clk);
            #2;
            drv_st = lfsr_step(drv_st);
          end
        end
        cmd_valid = 1'b1;
        cmd       = cmd_q[i];
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);  // Ready is settled mid-cycle
        @(posedge clk);                      // Transfer edge
        #2;
        cmd_valid = 1'b0;
      end
    end
  endtask

  task collect_responses;
    int   hold;  // Cycles left in a low stretch
    rsp_t e;
    begin
      hold = 0;
      report_finished();
      while (exp_done < exp_q.size()) begin
        @(posedge clk);
        #2;
        if (hold > 0) begin
          rsp_ready = 1'b0;
          hold--;
        end else if (test_bp[rep_test]) begin
          mon_st = lfsr_step(mon_st);
          rsp_ready = !mon_st[0];
          if (mon_st[0]) begin
            repeat (3) begin  // Stretch of 1 to 8 cycles
              mon_st = lfsr_step(mon_st);
              hold = (hold << 1) | int'(mon_st[0]);
            end
          end
        end else begin
          rsp_ready = 1'b1;
        end
        @(negedge clk);
        if (rsp_valid && rsp_ready) begin
          e = exp_q[exp_done];
          check("rsp.tag", 64'(rsp.tag), 64'(e.tag));
          check("rsp.data", rsp.data, e.data);
          check("rsp.err", 64'(rsp.err), 64'(e.err));
          exp_done++;
          report_finished();
        end
      end
    end
  endtask

  initial begin
    cmd_valid = 1'b0;
    cmd       = '0;
    rsp_ready = 1'b0;
    reset_N   = 1'b0;
    exp_done  = 0;
    rep_test  = 0;
    errors    = 0;
    n_pass    = 0;
    n_fail    = 0;
    cycles    = 0;
    limit     = 0;
    drv_st    = SEED;
    mon_st    = SEED;
    repeat (17) mon_st = lfsr_step(mon_st);  // Monitor runs ahead of driver
    read_trace();
    limit = 20 * cmd_q.size() + 100;
    repeat (5) @(posedge clk);
    #2;
    reset_N = 1'b1;
    fork
      drive_commands();
      collect_responses();
    join
    report_finished();
    // No stray response after the last expected one
    @(posedge clk);   // Last transfer edge
    #2;
    rsp_ready = 1'b0;  // Extra responses stay visible
    repeat (4) @(negedge clk);
    check("rsp_valid", 64'(rsp_valid), 64'h0);
    $display("%0d tests, %0d passed, %0d failed, %0d responses, %0d errors",
             test_name.size(), n_pass, n_fail, exp_done, errors);
    if (errors == 0 && n_fail == 0) $display("TB PASSED");
    else $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/rec_store_trace.txt */
# test <name> <gaps 0/1> <backpressure 0/1> | cmd <op> <addr> <tag> <data> | exp <tag> <data> <err>
# cmd and exp fields in hex; op 0 write, 1 read, 2 add, 3 swap, 4 to 7 illegal
test write_read 1 0
cmd 0 10 1 0123456789abcdef
cmd 0 ff 2 fedcba9876543210
cmd 0 00 3 00000000deadbeef
cmd 1 10 4 0
exp 4 0123456789abcdef 0
cmd 1 00 5 0
exp 5 00000000deadbeef 0
cmd 1 ff 6 0
exp 6 fedcba9876543210 0
test add 1 1
cmd 0 20 1 ffffffffffffff00
cmd 2 20 2 0000000000000010
exp 2 ffffffffffffff10 0
cmd 2 20 3 0000000000000100
exp 3 0000000000000010 0
cmd 1 20 4 0
exp 4 0000000000000010 0
test swap 1 1
cmd 0 30 1 1111111111111111
cmd 3 30 2 2222222222222222
exp 2 1111111111111111 0
cmd 1 30 3 0
exp 3 2222222222222222 0
test back_to_back 0 0
cmd 0 40 1 0000000000000005
cmd 2 40 2 0000000000000003
exp 2 0000000000000008 0
cmd 2 40 3 0000000000000004
exp 3 000000000000000c 0
cmd 3 40 4 0000000000000100
exp 4 000000000000000c 0
cmd 2 40 5 0000000000000001
exp 5 0000000000000101 0
cmd 1 40 6 0
exp 6 0000000000000101 0
test illegal 1 0
cmd 0 50 1 00000000cafef00d
cmd 4 50 2 ffffffffffffffff
exp 2 0 1
cmd 5 50 3 0000000000001234
exp 3 0 1
cmd 6 51 4 0
exp 4 0 1
cmd 7 50 5 0000000000000001
exp 5 0 1
cmd 1 50 6 0
exp 6 00000000cafef00d 0
test backpressure 0 1
cmd 0 60 0 0000000000000001
cmd 2 60 1 0000000000000001
exp 1 0000000000000002 0
cmd 2 60 2 0000000000000002
exp 2 0000000000000004 0
cmd 3 60 3 00000000000000a0
exp 3 0000000000000004 0
cmd 6 60 4 0
exp 4 0 1
cmd 2 60 5 0000000000000005
exp 5 00000000000000a5 0
cmd 1 60 6 0
exp 6 00000000000000a5 0
cmd 2 60 7 ffffffffffffff5b
exp 7 0000000000000000 0
cmd 1 60 8 0
exp 8 0000000000000000 0
cmd 3 60 9 0123456789abcdef
exp 9 0000000000000000 0
cmd 1 60 a 0
exp a 0123456789abcdef 0

/* common/rec_pkg.sv */
// Shared widths, opcode codes and stream payload structs
// for the tagged record store
`default_nettype none

package rec_pkg;

  typedef logic [7:0]  addr_t;   // 256 records
  typedef logic [63:0] word_t;   // Record data
  typedef logic [3:0]  tag_t;    // Caller's match tag
  typedef logic [2:0]  op_t;

  // Legal opcodes, 4 to 7 are illegal
  localparam op_t OP_WRITE = 3'd0;
  localparam op_t OP_READ  = 3'd1;
  localparam op_t OP_ADD   = 3'd2;
  localparam op_t OP_SWAP  = 3'd3;

  // Command stream payload
  typedef struct packed {
    op_t   op;
    addr_t addr;
    tag_t  tag;
    word_t data;
  } cmd_t;

  // Decoded command, flags drive the execute pipeline
  typedef struct packed {
    logic  rd;       // Needs the stored word
    logic  wr;       // Stores something
    logic  sum;      // Store old plus operand
    logic  rsp;      // Produces a response
    logic  ret_old;  // Respond with old word
    logic  err;      // Illegal opcode
    addr_t addr;
    tag_t  tag;
    word_t data;
  } dec_t;

  // Response stream payload
  typedef struct packed {
    tag_t  tag;
    word_t data;
    logic  err;
  } rsp_t;

endpackage

`default_nettype wire

/* compile.f */
common/rec_pkg.sv
rtl/execute/dp_ram.sv
rtl/execute/rmw_execute.sv
rtl/cmd_decode.sv
rtl/result_queue.sv
rtl/rec_store_top.sv
bench/rec_store_tb.sv

/* rtl/cmd_decode.sv */
// Command decode stage
// Opcode to control flags, one registered slot
`default_nettype none

module cmd_decode (
  input  wire logic          clk,
  input  wire logic          reset_N,
  input  wire logic          cmd_valid,
  output      logic          cmd_ready,
  input  wire rec_pkg::cmd_t cmd,
  output      logic          dec_valid,
  input  wire logic          dec_ready,
  output      rec_pkg::dec_t dec
);
  import rec_pkg::*;

  dec_t dec_next;  // Decoded form of incoming cmd
  logic up_q;      // Low for the first cycle out of reset
  logic accept;

  // Slot empty, or draining this cycle
  assign cmd_ready = up_q && (!dec_valid || dec_ready);
  assign accept    = cmd_valid && cmd_ready;

  always_comb begin
    dec_next      = '0;
    dec_next.addr = cmd.addr;
    dec_next.tag  = cmd.tag;
    dec_next.data = cmd.data;
    case (cmd.op)
      OP_WRITE: dec_next.wr = 1'b1;  // Silent store
      OP_READ: begin
        dec_next.rd      = 1'b1;
        dec_next.rsp     = 1'b1;
        dec_next.ret_old = 1'b1;  // Stored word unchanged
      end
      OP_ADD: begin
        dec_next.rd  = 1'b1;
        dec_next.wr  = 1'b1;
        dec_next.sum = 1'b1;
        dec_next.rsp = 1'b1;      // Returns the sum
      end
      OP_SWAP: begin
        dec_next.rd      = 1'b1;
        dec_next.wr      = 1'b1;
        dec_next.rsp     = 1'b1;
        dec_next.ret_old = 1'b1;
      end
      default: begin
        // Error response only, memory untouched
        dec_next.err = 1'b1;
        dec_next.rsp = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      up_q      <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      up_q <= 1'b1;
      if (accept) dec_valid <= 1'b1;
      else if (dec_ready) dec_valid <= 1'b0;  // Taken by execute
    end
  end

  always_ff @(posedge clk) begin
    if (accept) dec <= dec_next;
  end

  // Illegal ops must never reach the RAM write port
  a_err_no_wr: assert property (@(posedge clk) disable iff (!reset_N)
    dec_valid |-> !(dec.err && dec.wr));

endmodule

`default_nettype wire

/* rtl/execute/dp_ram.sv */
// Record memory, one registered read port and one write port
`default_nettype none

module dp_ram (
  input  wire logic           clk,
  input  wire logic           rd_en,
  input  wire rec_pkg::addr_t rd_addr,
  output      rec_pkg::word_t rd_data,
  input  wire logic           wr_en,
  input  wire rec_pkg::addr_t wr_addr,
  input  wire rec_pkg::word_t wr_data
);
  import rec_pkg::*;

  localparam int DEPTH = 1 << $bits(addr_t);  // Full address space

  word_t mem [DEPTH];  // Contents undefined after reset

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  // Read port, old word on a same-address collision
  always_ff @(posedge clk) begin
    if (rd_en) rd_data <= mem[rd_addr];  // Holds otherwise
  end

endmodule

`default_nettype wire

/* rtl/execute/rmw_execute.sv */
// Two-stage read-modify-write pipeline
// RAM read in stage A, modify, write and push in stage B
`default_nettype none

module rmw_execute (
  input  wire logic          clk,
  input  wire logic          reset_N,
  input  wire logic          dec_valid,
  output      logic          dec_ready,
  input  wire rec_pkg::dec_t dec,
  output      logic          push,
  output      rec_pkg::rsp_t push_rsp,
  input  wire logic          room
);
  import rec_pkg::*;

  logic  a_valid;
  dec_t  a_dec;
  logic  b_valid;
  dec_t  b_dec;
  logic  b_fwd;       // B's old word comes from forward reg
  word_t b_fwd_data;
  word_t b_old;
  word_t b_new;
  logic  stall;       // B must respond but queue is full

  logic  rd_en;
  addr_t rd_addr;
  word_t rd_data;
  logic  wr_en;
  addr_t wr_addr;
  word_t wr_data;

  assign stall     = b_valid && b_dec.rsp && !room;
  assign dec_ready = !stall;

  // Read issued from A, data lands for B
  assign rd_en   = a_valid && a_dec.rd && !stall;  // Holds read reg on stall
  assign rd_addr = a_dec.addr;

  // RAM read of the same edge misses B's write
  assign b_old = b_fwd ? b_fwd_data : rd_data;
  assign b_new = b_dec.sum ? b_old + b_dec.data : b_dec.data;  // Wraps mod 2^64

  // Write and push only on the edge that leaves B
  assign wr_en   = b_valid && b_dec.wr && !stall;
  assign wr_addr = b_dec.addr;
  assign wr_data = b_new;
  assign push    = b_valid && b_dec.rsp && !stall;

  always_comb begin
    push_rsp.tag = b_dec.tag;
    push_rsp.err = b_dec.err;
    if (b_dec.err) push_rsp.data = '0;
    else push_rsp.data = b_dec.ret_old ? b_old : b_new;
  end

  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      a_valid <= 1'b0;
      b_valid <= 1'b0;
      b_fwd   <= 1'b0;
    end else if (!stall) begin
      a_valid <= dec_valid;  // dec_ready is high here
      b_valid <= a_valid;
      b_fwd   <= wr_en && (wr_addr == a_dec.addr);  // Same-edge hazard
    end
  end

  // Payload regs
  always_ff @(posedge clk) begin
    if (!stall) begin
      a_dec      <= dec;
      b_dec      <= a_dec;
      b_fwd_data <= wr_data;
    end
  end

  dp_ram i_dp_ram (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  // Queue's room flag gates every push
  a_push_room: assert property (@(posedge clk) disable iff (!reset_N)
    push |-> room);

endmodule

`default_nettype wire

/* rtl/rec_store_top.sv */
// Record store top level
// Decode slot, read-modify-write pipeline, in-order response queue
`default_nettype none

module rec_store_top #(
  parameter int RESULT_DEPTH = 4  // Response FIFO entries
) (
  input  wire logic          clk,
  input  wire logic          reset_N,
  // Command stream
  input  wire logic          cmd_valid,
  output      logic          cmd_ready,
  input  wire rec_pkg::cmd_t cmd,
  // Response stream
  output      logic          rsp_valid,
  input  wire logic          rsp_ready,
  output      rec_pkg::rsp_t rsp
);
  import rec_pkg::*;

  // Decode to execute
  logic dec_valid;
  logic dec_ready;
  dec_t dec;

  // Execute to queue
  logic push;
  rsp_t push_rsp;
  logic room;  // Queue not full

  cmd_decode i_cmd_decode (
    .clk       (clk),
    .reset_N   (reset_N),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec)
  );

  rmw_execute i_rmw_execute (
    .clk       (clk),
    .reset_N   (reset_N),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec),
    .push      (push),
    .push_rsp  (push_rsp),
    .room      (room)
  );

  result_queue #(
    .RESULT_DEPTH (RESULT_DEPTH)
  ) i_result_queue (
    .clk       (clk),
    .reset_N   (reset_N),
    .push      (push),
    .push_rsp  (push_rsp),
    .room      (room),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

/* rtl/result_queue.sv */
// In-order response FIFO
// Circular buffer with count, valid/ready output
`default_nettype none

module result_queue #(
  parameter int RESULT_DEPTH = 4  // 2 or more
) (
  input  wire logic          clk,
  input  wire logic          reset_N,
  input  wire logic          push,
  input  wire rec_pkg::rsp_t push_rsp,
  output      logic          room,
  output      logic          rsp_valid,
  input  wire logic          rsp_ready,
  output      rec_pkg::rsp_t rsp
);
  import rec_pkg::*;

  localparam int PW = $clog2(RESULT_DEPTH);
  localparam int CW = $clog2(RESULT_DEPTH + 1);

  rsp_t          buf_q [RESULT_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          pop;

  assign room      = count < CW'(RESULT_DEPTH);
  assign rsp_valid = count != '0;
  assign rsp       = buf_q[rd_ptr];
  assign pop       = rsp_valid && rsp_ready;

  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // Wrap explicitly, depth need not be a power of two
        wr_ptr <= (wr_ptr == PW'(RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) buf_q[wr_ptr] <= push_rsp;
  end

  // Overflow would drop a response
  a_no_push_full: assert property (@(posedge clk) disable iff (!reset_N)
    push |-> count < CW'(RESULT_DEPTH));

  // Underflow would replay a stale entry
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_N)
    pop |-> count != '0);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the record store testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module rec_store_tb -Mdir obj_dir
out=$(./obj_dir/Vrec_store_tb || true)
echo "$out"
if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
else
  exit 1
fi
